/* compile.f */
design/slot_pkg.sv
design/reel_motion.sv
design/spin_sequencer.sv
design/reel_renderer.sv
design/slot_reels_top.sv
tb/tb_clock.sv
tb/slot_reels_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module slot_reels_tb

sim:
	verilator --binary --timing --assert -f compile.f --top-module slot_reels_tb -o slot_sim
	./obj_dir/slot_sim | tee $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tb/slot_reels_tb.sv */
`default_nettype none

module slot_reels_tb
    import slot_pkg::*;
();

    localparam int CLK_PERIOD    = 8;
    localparam int NUM_ROWS      = 6;
    localparam int FRAME_LIMIT   = 700;
    localparam int WATCHDOG_TIME = NUM_ROWS * FRAME_LIMIT * 4 * CLK_PERIOD * 2;
    localparam int CENTER_LINE   = 275;

    logic                    clk;
    logic                    por_n;
    logic                    row_rst_n;
    logic                    reset_n;
    logic [10:0]             hcount;
    logic [9:0]              vcount;
    logic                    vsync;
    logic                    active_video;
    symbol_t [NUM_REELS-1:0] final_symbol;
    logic                    start_spin;
    logic [2:0]              pixel_rgb;
    logic                    done;

    logic [31:0] rng_state = 32'h15a4_4323;
    int model_offset [NUM_REELS] = '{0, 0, 0};

    // requested symbols per row and the colour each centre line must show
    symbol_t row_symbols [NUM_ROWS][NUM_REELS] = '{
        '{3'd0, 3'd0, 3'd0},
        '{3'd6, 3'd6, 3'd6},
        '{3'd3, 3'd1, 3'd5},
        '{3'd1, 3'd4, 3'd2},
        '{3'd5, 3'd2, 3'd0},
        '{3'd2, 3'd6, 3'd4}
    };
    int row_colors [NUM_ROWS][NUM_REELS] = '{
        '{1, 1, 1},
        '{7, 7, 7},
        '{4, 2, 6},
        '{2, 5, 3},
        '{6, 3, 1},
        '{3, 7, 5}
    };

    assign reset_n = por_n && row_rst_n;

    tb_clock #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (2)
    ) u_clock (
        .clk     (clk),
        .reset_n (por_n)
    );

    slot_reels_top DUT (
        .clk          (clk),
        .reset_n      (reset_n),
        .hcount       (hcount),
        .vcount       (vcount),
        .vsync        (vsync),
        .active_video (active_video),
        .final_symbol (final_symbol),
        .start_spin   (start_spin),
        .pixel_rgb    (pixel_rgb),
        .done         (done)
    );

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int expected_color(input int h, input int v, input bit act);
        int line;
        int color;
        color = 0;
        if (act && v >= REELS_START_V && v < REELS_START_V + REEL_DISPLAY_HEIGHT) begin
            for (int k = 0; k < NUM_REELS; k++) begin
                if (h >= REEL_START_H[k] && h < REEL_START_H[k] + REEL_WIDTH) begin
                    line  = (v - REELS_START_V + model_offset[k]) % TOTAL_HEIGHT;
                    color = int'(SYMBOL_COLOR[REEL_SEQUENCE[k][line / SLOT_HEIGHT]]);
                end
            end
        end
        return color;
    endfunction

    // resting offset that centres the symbol in the window
    function automatic int end_offset_of(input int reel, input int sym);
        int pos;
        pos = 0;
        for (int i = 0; i < NUM_SYMBOLS; i++) begin
            if (int'(REEL_SEQUENCE[reel][i]) == sym) begin
                pos = i;
            end
        end
        return (pos * SLOT_HEIGHT + TOTAL_HEIGHT - CENTER_OFFSET) % TOTAL_HEIGHT;
    endfunction

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input int actual, input int expected);
        if (actual != expected) begin
            abort_run($sformatf("error at %0t: %s = %0d, expected %0d",
                                $time, name, actual, expected));
        end
    endtask

    // one beam position, result two clocks later
    task automatic check_pixel(input int h, input int v, input bit act, input int expected);
        @(posedge clk);
        hcount       <= 11'(h);
        vcount       <= 10'(v);
        active_video <= act;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_value("pixel_rgb", int'(pixel_rgb), expected);
    endtask

    task automatic check_outside();
        check_pixel(100, 200, 1'b1, 0);
        check_pixel(350, 200, 1'b1, 0);
        check_pixel(760, 200, 1'b1, 0);
        check_pixel(250, 40, 1'b1, 0);
        check_pixel(250, 495, 1'b1, 0);
        check_pixel(250, 200, 1'b0, 0);
        // reel 0, second slot at offset 0
        check_pixel(250, 200, 1'b1, 2);
    endtask

    // back-to-back pixels, two in flight
    task automatic check_random_pixels(input int count);
        int exp_q [$];
        int h;
        int v;
        bit act;
        for (int i = 0; i < count + 2; i++) begin
            @(posedge clk);
            if (i < count) begin
                rng_state = lcg_next(rng_state);
                h   = int'(rng_state[31:22]) % 900;
                v   = int'(rng_state[21:12]) % 525;
                act = rng_state[7] || rng_state[3];
                hcount       <= 11'(h);
                vcount       <= 10'(v);
                active_video <= act;
                exp_q.push_back(expected_color(h, v, act));
            end
            @(negedge clk);
            if (i >= 2) begin
                check_value("pixel_rgb", int'(pixel_rgb), exp_q.pop_front());
            end
        end
    endtask

    // vsync low one clock, high three
    task automatic run_frame(output int pulses);
        pulses = 0;
        for (int c = 0; c < 4; c++) begin
            @(posedge clk);
            vsync <= (c != 0);
            @(negedge clk);
            if (done) begin
                pulses++;
            end
        end
    endtask

    task automatic spin_row(input int r);
        int pulses;
        int frames;
        @(posedge clk);
        row_rst_n  <= 1'b0;
        start_spin <= 1'b0;
        @(negedge clk);
        check_value("done", int'(done), 0);
        check_value("pixel_rgb", int'(pixel_rgb), 0);
        repeat (2) @(posedge clk);
        row_rst_n    <= 1'b1;
        final_symbol <= {row_symbols[r][2], row_symbols[r][1], row_symbols[r][0]};
        start_spin   <= 1'b1;
        frames = 0;
        pulses = 0;
        while (pulses == 0) begin
            if (frames == FRAME_LIMIT) begin
                abort_run($sformatf("row %0d: done did not arrive within %0d frames",
                                    r, FRAME_LIMIT));
            end else begin
                run_frame(pulses);
                frames++;
            end
        end
        check_value("done pulse count", pulses, 1);
        // start_spin stays high, the engine must stay finished
        for (int f = 0; f < 20; f++) begin
            run_frame(pulses);
            check_value("done after finish", pulses, 0);
        end
        for (int k = 0; k < NUM_REELS; k++) begin
            model_offset[k] = end_offset_of(k, int'(row_symbols[r][k]));
            check_pixel(REEL_START_H[k] + REEL_WIDTH / 2, CENTER_LINE, 1'b1, row_colors[r][k]);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////
    initial begin
        hcount       = '0;
        vcount       = '0;
        vsync        = 1'b1;
        active_video = 1'b0;
        final_symbol = '0;
        start_spin   = 1'b0;
        row_rst_n    = 1'b1;
        wait (por_n === 1'b1);
        @(negedge clk);
        check_value("done", int'(done), 0);
        check_value("pixel_rgb", int'(pixel_rgb), 0);
        check_outside();
        check_random_pixels(64);
        for (int r = 0; r < NUM_ROWS; r++) begin
            spin_row(r);
        end
        check_random_pixels(64);
        $display("*** PASSED ***");
        $finish;
    end

    initial begin
        #(WATCHDOG_TIME);
        abort_run($sformatf("timeout: run still busy after %0d time units", WATCHDOG_TIME));
    end

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
`default_nettype none

module tb_clock #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // power-on reset, released on a rising edge
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* design/slot_reels_top.sv */
`default_nettype none

module slot_reels_top
    import slot_pkg::*;
(
    input  wire         clk,
    input  wire         reset_n,
    input  wire  [10:0] hcount,
    input  wire  [9:0]  vcount,
    input  wire         vsync,
    input  wire         active_video,
    input  wire symbol_t [NUM_REELS-1:0] final_symbol,
    input  wire         start_spin,
    output logic [2:0]  pixel_rgb,
    output logic        done
);

    logic          frame_tick;
    reel_cmd_t     [NUM_REELS-1:0] cmd;
    reel_stat_t    [NUM_REELS-1:0] stat;
    reel_offsets_t offsets;

    spin_sequencer u_sequencer (
        .clk        (clk),
        .reset_n    (reset_n),
        .vsync      (vsync),
        .start_spin (start_spin),
        .stat       (stat),
        .frame_tick (frame_tick),
        .cmd        (cmd),
        .done       (done)
    );

    // one motion block per reel
    for (genvar g = 0; g < NUM_REELS; g++) begin : g_reel
        reel_motion #(
            .REEL (g)
        ) u_reel (
            .clk        (clk),
            .reset_n    (reset_n),
            .frame_tick (frame_tick),
            .symbol     (final_symbol[g]),
            .cmd        (cmd[g]),
            .offset     (offsets[g]),
            .stat       (stat[g])
        );
    end

    reel_renderer u_renderer (
        .clk          (clk),
        .reset_n      (reset_n),
        .hcount       (hcount),
        .vcount       (vcount),
        .active_video (active_video),
        .offsets      (offsets),
        .pixel_rgb    (pixel_rgb)
    );

endmodule

`default_nettype wire

/* design/reel_renderer.sv */
`default_nettype none

module reel_renderer
    import slot_pkg::*;
(
    input  wire         clk,
    input  wire         reset_n,
    input  wire  [10:0] hcount,
    input  wire  [9:0]  vcount,
    input  wire         active_video,
    input  wire reel_offsets_t offsets,
    output logic [2:0]  pixel_rgb
);

    typedef logic [OFFSET_W:0] wide_t;

    typedef struct packed {
        logic    active;
        logic    hit;
        symbol_t symbol;
    } pix_stage_t;

    logic [NUM_REELS-1:0] hit;
    logic       in_rows;
    wide_t      line_sum;
    offset_t    line;
    logic [2:0] slot;
    symbol_t    sym;
    pix_stage_t s1;

    ////////////////////////////////////////////////////////////
    // stage 0, window test and symbol lookup
    ////////////////////////////////////////////////////////////
    assign in_rows = (vcount >= 10'(REELS_START_V))
                  && (vcount < 10'(REELS_START_V + REEL_DISPLAY_HEIGHT));

    always_comb begin
        hit      = '0;
        line_sum = '0;
        line     = '0;
        slot     = '0;
        sym      = '0;
        for (int k = 0; k < NUM_REELS; k++) begin
            hit[k] = in_rows
                  && (hcount >= 11'(REEL_START_H[k]))
                  && (hcount < 11'(REEL_START_H[k] + REEL_WIDTH));
            if (hit[k]) begin
                // line inside the reel strip, one lap at most past the end
                line_sum = wide_t'(vcount - 10'(REELS_START_V)) + wide_t'(offsets[k]);
                if (line_sum >= wide_t'(TOTAL_HEIGHT)) begin
                    line = offset_t'(line_sum - wide_t'(TOTAL_HEIGHT));
                end else begin
                    line = offset_t'(line_sum);
                end
                slot = 3'(line / offset_t'(SLOT_HEIGHT));
                sym  = REEL_SEQUENCE[k][slot];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stage 1 and 2
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            s1        <= '0;
            pixel_rgb <= '0;
        end else begin
            s1.active <= active_video;
            s1.hit    <= |hit;
            s1.symbol <= sym;
            if (s1.active && s1.hit) begin
                pixel_rgb <= SYMBOL_COLOR[s1.symbol];
            end else begin
                pixel_rgb <= '0;
            end
        end
    end

    // windows do not overlap
    one_window: assert property (@(posedge clk) disable iff (!reset_n)
        $onehot0(hit));

endmodule

`default_nettype wire

/* design/spin_sequencer.sv */
`default_nettype none

module spin_sequencer
    import slot_pkg::*;
(
    input  wire        clk,
    input  wire        reset_n,
    input  wire        vsync,
    input  wire        start_spin,
    input  wire reel_stat_t [NUM_REELS-1:0] stat,
    output logic       frame_tick,
    output reel_cmd_t [NUM_REELS-1:0] cmd,
    output logic       done
);

    typedef enum logic [2:0] {
        IDLE,
        SPINNING,
        STOP1,
        STOP2,
        STOP3,
        FINISHED
    } state_t;

    state_t state;
    state_t state_d;
    logic   vsync_prev;
    logic   load_q;
    logic   last_rest;
    logic [NUM_REELS-1:0] settle_lvl;

    ////////////////////////////////////////////////////////////
    // frame tick on vsync falling edge
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            vsync_prev <= 1'b1;
            frame_tick <= 1'b0;
        end else begin
            vsync_prev <= vsync;
            frame_tick <= vsync_prev && !vsync;
        end
    end

    // the third reel coming to rest ends the spin
    assign last_rest = stat[2].at_rest;

    always_comb begin
        state_d = state;
        case (state)
            IDLE:     if (start_spin) state_d = SPINNING;
            SPINNING: if (stat[0].lap_out) state_d = STOP1;
            STOP1:    if (stat[1].lap_out) state_d = STOP2;
            STOP2:    if (stat[2].lap_out) state_d = STOP3;
            STOP3:    if (last_rest) state_d = FINISHED;
            default:  state_d = state;
        endcase
    end

    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            state  <= IDLE;
            load_q <= 1'b0;
            done   <= 1'b0;
        end else begin
            state  <= state_d;
            load_q <= (state == IDLE) && start_spin;
            done   <= (state == STOP3) && last_rest;
        end
    end

    // reel k settles from its own stop state onward
    always_comb begin
        settle_lvl[0] = state inside {STOP1, STOP2, STOP3, FINISHED};
        settle_lvl[1] = state inside {STOP2, STOP3, FINISHED};
        settle_lvl[2] = state inside {STOP3, FINISHED};
        for (int k = 0; k < NUM_REELS; k++) begin
            cmd[k].load   = load_q;
            cmd[k].run    = (state != IDLE);
            cmd[k].settle = settle_lvl[k];
        end
    end

    done_single: assert property (@(posedge clk) disable iff (!reset_n)
        done |=> !done);

endmodule

`default_nettype wire

/* design/reel_motion.sv */
`default_nettype none

module reel_motion
    import slot_pkg::*;
#(
    parameter int REEL = 0
) (
    input  wire        clk,
    input  wire        reset_n,
    input  wire        frame_tick,
    input  wire symbol_t   symbol,
    input  wire reel_cmd_t cmd,
    output offset_t    offset,
    output reel_stat_t stat
);

    // one bit of headroom for sums before the lap wrap
    typedef logic [OFFSET_W:0] wide_t;

    symbol_t   sym_q;
    logic [2:0] pos;
    wide_t     end_sum;
    offset_t   end_offset;
    logic [1:0] laps;
    wide_t     spin_sum;
    logic      wrap;
    offset_t   spin_next;
    wide_t     gap;
    wide_t     settle_sum;
    offset_t   settle_next;
    logic      step;

    always_ff @(posedge clk) begin
        if (cmd.load) begin
            sym_q <= symbol;
        end
    end

    ////////////////////////////////////////////////////////////
    // ending offset
    ////////////////////////////////////////////////////////////

    // where the requested symbol sits in this reel's row
    always_comb begin
        pos = '0;
        for (int i = 0; i < NUM_SYMBOLS; i++) begin
            if (REEL_SEQUENCE[REEL][i] == sym_q) begin
                pos = 3'(i);
            end
        end
    end

    assign end_sum = wide_t'(pos) * wide_t'(SLOT_HEIGHT)
                   + wide_t'(TOTAL_HEIGHT - CENTER_OFFSET);
    assign end_offset = (end_sum >= wide_t'(TOTAL_HEIGHT))
                      ? offset_t'(end_sum - wide_t'(TOTAL_HEIGHT))
                      : offset_t'(end_sum);

    ////////////////////////////////////////////////////////////
    // next offsets
    ////////////////////////////////////////////////////////////
    assign spin_sum  = wide_t'(offset) + wide_t'(SPIN_STEP);
    assign wrap      = spin_sum >= wide_t'(TOTAL_HEIGHT);
    assign spin_next = wrap ? offset_t'(spin_sum - wide_t'(TOTAL_HEIGHT)) : offset_t'(spin_sum);

    // forward distance to the ending offset, round the lap if needed
    assign gap = (end_offset >= offset)
               ? wide_t'(end_offset) - wide_t'(offset)
               : wide_t'(end_offset) + wide_t'(TOTAL_HEIGHT) - wide_t'(offset);

    assign settle_sum  = wide_t'(offset) + wide_t'(SETTLE_STEP);
    assign settle_next = (gap <= wide_t'(SETTLE_STEP)) ? end_offset
                       : (settle_sum >= wide_t'(TOTAL_HEIGHT))
                       ? offset_t'(settle_sum - wide_t'(TOTAL_HEIGHT))
                       : offset_t'(settle_sum);

    // load wins over a coincident tick
    assign step = frame_tick && cmd.run && !cmd.load;

    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            offset <= '0;
            laps   <= 2'(SPIN_LAPS[REEL]);
        end else if (cmd.load) begin
            laps <= 2'(SPIN_LAPS[REEL]);
        end else if (step) begin
            if (cmd.settle) begin
                offset <= settle_next;
            end else begin
                offset <= spin_next;
                if (wrap && laps != 2'd0) begin
                    laps <= laps - 2'd1;
                end
            end
        end
    end

    always_comb begin
        stat.lap_out = step && !cmd.settle && wrap && (laps == 2'd0);
        stat.at_rest = cmd.settle && (offset == end_offset);
    end

    offset_in_lap: assert property (@(posedge clk) disable iff (!reset_n)
        offset < OFFSET_W'(TOTAL_HEIGHT));

endmodule

`default_nettype wire

/* design/slot_pkg.sv */
`default_nettype none

package slot_pkg;

    // counts and field widths
    localparam int NUM_REELS   = 3;
    localparam int NUM_SYMBOLS = 7;
    localparam int OFFSET_W    = 10;
    localparam int SYMBOL_W    = 3;

    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [SYMBOL_W-1:0] symbol_t;

    ////////////////////////////////////////////////////////////
    // raster geometry
    ////////////////////////////////////////////////////////////
    localparam int SLOT_HEIGHT         = 128;
    localparam int TOTAL_HEIGHT        = NUM_SYMBOLS * SLOT_HEIGHT;
    localparam int REEL_WIDTH          = 128;
    localparam int REEL_START_H [NUM_REELS] = '{190, 398, 606};
    localparam int REELS_START_V       = 60;
    localparam int REEL_DISPLAY_HEIGHT = 430;
    // puts the middle of a slot on the middle of the window
    localparam int CENTER_OFFSET       = REEL_DISPLAY_HEIGHT / 2 - SLOT_HEIGHT / 2;

    // motion per frame
    localparam int SPIN_STEP   = 24;
    localparam int SETTLE_STEP = 12;
    // extra laps before each reel may stop
    localparam int SPIN_LAPS [NUM_REELS] = '{3, 2, 2};

    ////////////////////////////////////////////////////////////
    // symbol tables
    ////////////////////////////////////////////////////////////
    localparam symbol_t REEL_SEQUENCE [NUM_REELS][NUM_SYMBOLS] = '{
        '{3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd6},
        '{3'd2, 3'd5, 3'd0, 3'd6, 3'd3, 3'd1, 3'd4},
        '{3'd5, 3'd3, 3'd1, 3'd4, 3'd2, 3'd0, 3'd6}
    };

    // flat colour per symbol, never black
    localparam logic [2:0] SYMBOL_COLOR [NUM_SYMBOLS] = '{
        3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd6, 3'd7
    };

    // sequencer to reel
    typedef struct packed {
        logic load;
        logic run;
        logic settle;
    } reel_cmd_t;

    // reel to sequencer
    typedef struct packed {
        logic lap_out;
        logic at_rest;
    } reel_stat_t;

    typedef offset_t [NUM_REELS-1:0] reel_offsets_t;

endpackage

`default_nettype wire
